/* rtl/rv_pkg.sv */
/*
 * RV32I subset definitions shared by the core, the bus slave and the testbench.
 * Holds major opcodes, ALU operations, instruction views and the address map.
 */
package rv_pkg;

  // Major opcodes of the supported subset
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_opimm  = 7'b0010011;
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_e;

  // One instruction word seen through three field layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } sb;
  } instr_u;

  // Address map
  localparam logic [31:0] gpio_addr = 32'h0000_1000;
  localparam logic [31:0] reset_pc  = 32'h0000_0000;

endpackage

/* rtl/rv_decode.sv */
/*
 * Instruction decoder. Extracts register indices and the immediate, picks
 * the ALU operation and control flags, and flags words outside the subset.
 */
`timescale 1ns/1ps

module rv_decode (
  input  rv_pkg::instr_u  instr,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output logic [4:0]      rd,
  output logic [31:0]     imm,
  output rv_pkg::alu_op_e alu_op,
  output logic            use_imm,
  output logic            reg_write,
  output logic            is_load,
  output logic            is_store,
  output logic            is_branch,
  output logic            branch_ne,
  output logic            is_jal,
  output logic            is_lui,
  output logic            illegal
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign opcode = instr.r.opcode;
  assign funct3 = instr.r.funct3;
  assign funct7 = instr.r.funct7;
  assign rd     = instr.r.rd;
  assign rs1    = instr.r.rs1;
  assign rs2    = instr.sb.rs2;

  // Sign-extended immediates per format
  assign imm_i = {{20{instr.i.imm12[11]}}, instr.i.imm12};
  assign imm_s = {{20{instr.sb.imm_hi[6]}}, instr.sb.imm_hi, instr.sb.imm_lo};
  assign imm_b = {{20{instr.sb.imm_hi[6]}}, instr.sb.imm_lo[0], instr.sb.imm_hi[5:0],
                  instr.sb.imm_lo[4:1], 1'b0};
  assign imm_u = {instr.i.imm12, instr.i.rs1, instr.i.funct3, 12'b0};
  // J layout is imm[20|10:1|11|19:12] in bits 31:12
  assign imm_j = {{12{instr.i.imm12[11]}}, instr.i.rs1, instr.i.funct3, instr.i.imm12[0],
                  instr.i.imm12[10:1], 1'b0};

  always_comb begin
    imm       = '0;
    alu_op    = rv_pkg::alu_add;
    use_imm   = 1'b0;
    reg_write = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    is_jal    = 1'b0;
    is_lui    = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      rv_pkg::op_lui: begin
        imm       = imm_u;
        alu_op    = rv_pkg::alu_pass_b;
        use_imm   = 1'b1;
        reg_write = 1'b1;
        is_lui    = 1'b1;
      end
      rv_pkg::op_opimm: begin
        imm       = imm_i;
        use_imm   = 1'b1;
        reg_write = 1'b1;
        case (funct3)
          3'b000:  alu_op = rv_pkg::alu_add;
          3'b100:  alu_op = rv_pkg::alu_xor;
          3'b110:  alu_op = rv_pkg::alu_or;
          3'b111:  alu_op = rv_pkg::alu_and;
          default: illegal = 1'b1;
        endcase
      end
      rv_pkg::op_op: begin
        reg_write = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: alu_op = rv_pkg::alu_add;
          10'b0100000_000: alu_op = rv_pkg::alu_sub;
          10'b0000000_111: alu_op = rv_pkg::alu_and;
          10'b0000000_110: alu_op = rv_pkg::alu_or;
          10'b0000000_100: alu_op = rv_pkg::alu_xor;
          10'b0000000_010: alu_op = rv_pkg::alu_slt;
          default:         illegal = 1'b1;
        endcase
      end
      rv_pkg::op_load: begin
        imm       = imm_i;
        use_imm   = 1'b1;
        reg_write = 1'b1;
        is_load   = 1'b1;
        // Word accesses only
        illegal   = funct3 != 3'b010;
      end
      rv_pkg::op_store: begin
        imm      = imm_s;
        use_imm  = 1'b1;
        is_store = 1'b1;
        illegal  = funct3 != 3'b010;
      end
      rv_pkg::op_branch: begin
        imm       = imm_b;
        is_branch = 1'b1;
        branch_ne = funct3[0];
        // BEQ and BNE only
        illegal   = funct3[2:1] != 2'b00;
      end
      rv_pkg::op_jal: begin
        imm       = imm_j;
        is_jal    = 1'b1;
        reg_write = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
    // Side effects are suppressed for anything outside the subset
    if (illegal) begin
      reg_write = 1'b0;
      is_store  = 1'b0;
    end
  end

  always_comb begin
    assert (!(illegal && reg_write))
      else $error("decode: illegal word with register write enabled");
  end

endmodule

/* rtl/rv_execute.sv */
/*
 * Execute stage. ALU, branch compare and next-PC selection; the ALU adder
 * also forms the load and store address.
 */
`timescale 1ns/1ps

module rv_execute (
  input  logic [31:0]     pc,
  input  logic [31:0]     a,
  input  logic [31:0]     b,
  input  logic [31:0]     imm,
  input  rv_pkg::alu_op_e alu_op,
  input  logic            use_imm,
  input  logic            is_branch,
  input  logic            branch_ne,
  input  logic            is_jal,
  output logic [31:0]     alu_y,
  output logic [31:0]     next_pc,
  output logic [31:0]     link
);

  logic [31:0] op_b;
  logic [31:0] target;
  logic        equal;
  logic        taken;

  assign op_b = use_imm ? imm : b;

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:    alu_y = a + op_b;
      rv_pkg::alu_sub:    alu_y = a - op_b;
      rv_pkg::alu_and:    alu_y = a & op_b;
      rv_pkg::alu_or:     alu_y = a | op_b;
      rv_pkg::alu_xor:    alu_y = a ^ op_b;
      rv_pkg::alu_slt:    alu_y = {31'b0, $signed(a) < $signed(op_b)};
      rv_pkg::alu_pass_b: alu_y = op_b;
      default:            alu_y = op_b;
    endcase
  end

  // Branch compare always uses the register operands
  assign equal = a == b;
  assign taken = is_branch && (branch_ne ? !equal : equal);

  // PC-relative target shared by branches and JAL
  assign target  = pc + imm;
  assign link    = pc + 32'd4;
  assign next_pc = (is_jal || taken) ? target : link;

endmodule

/* rtl/rv_result.sv */
/*
 * Register file with two read ports and write-back source selection
 * between ALU result, load data and link address.
 */
`timescale 1ns/1ps

module rv_result (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        we,
  input  logic        sel_load,
  input  logic        sel_link,
  input  logic [31:0] alu_y,
  input  logic [31:0] load_data,
  input  logic [31:0] link,
  output logic [31:0] a,
  output logic [31:0] b
);

  // x0 is cleared by reset and never written
  logic [31:0] regs [0:31];
  logic [31:0] wr_data;

  assign wr_data = sel_load ? load_data : (sel_link ? link : alu_y);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wr_data;
    end
  end

  assign a = regs[rs1];
  assign b = regs[rs2];

  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (rs1 != 5'd0 || a == '0) && (rs2 != 5'd0 || b == '0))
    else $error("regfile: x0 read back nonzero");

endmodule

/* rtl/riscv_core.sv */
/*
 * Multi-cycle RV32I subset core with a single-beat AXI master.
 * One instruction in flight; illegal words or bus errors halt with trap set.
 */
`timescale 1ns/1ps

module riscv_core (
  input  logic        clk,
  input  logic        rst_n,
  output logic [31:0] awaddr,
  output logic        awvalid,
  input  logic        awready,
  output logic [31:0] wdata,
  output logic [3:0]  wstrb,
  output logic        wvalid,
  input  logic        wready,
  input  logic [1:0]  bresp,
  input  logic        bvalid,
  output logic        bready,
  output logic [31:0] araddr,
  output logic        arvalid,
  input  logic        arready,
  input  logic [31:0] rdata,
  input  logic [1:0]  rresp,
  input  logic        rvalid,
  output logic        rready,
  output logic        trap
);

  localparam logic [2:0] st_fetch_addr = 3'd0;
  localparam logic [2:0] st_fetch_data = 3'd1;
  localparam logic [2:0] st_execute    = 3'd2;
  localparam logic [2:0] st_load_addr  = 3'd3;
  localparam logic [2:0] st_load_data  = 3'd4;
  localparam logic [2:0] st_store      = 3'd5;
  localparam logic [2:0] st_store_resp = 3'd6;
  localparam logic [2:0] st_halted     = 3'd7;

  logic [2:0]      state;
  logic [31:0]     pc;
  rv_pkg::instr_u  ir;
  logic [4:0]      rs1, rs2, rd, rf_rs1;
  logic [31:0]     imm, a, b, alu_y, next_pc, link;
  rv_pkg::alu_op_e alu_op;
  logic            use_imm, reg_write, is_load, is_store;
  logic            is_branch, branch_ne, is_jal, is_lui, illegal;
  logic            exec_done, load_done, rf_we;

  rv_decode u_decode (
    .instr(ir), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
    .use_imm(use_imm), .reg_write(reg_write), .is_load(is_load), .is_store(is_store),
    .is_branch(is_branch), .branch_ne(branch_ne), .is_jal(is_jal), .is_lui(is_lui),
    .illegal(illegal)
  );

  rv_execute u_execute (
    .pc(pc), .a(a), .b(b), .imm(imm), .alu_op(alu_op), .use_imm(use_imm),
    .is_branch(is_branch), .branch_ne(branch_ne), .is_jal(is_jal),
    .alu_y(alu_y), .next_pc(next_pc), .link(link)
  );

  // U-format has no rs1 field, those bits belong to the immediate
  assign rf_rs1 = is_lui ? 5'd0 : rs1;

  // Write-back happens on the edge that ends the instruction
  assign exec_done = state == st_execute && !illegal && !is_load && !is_store;
  assign load_done = state == st_load_data && rvalid && rresp == 2'b00;
  assign rf_we     = (exec_done || load_done) && reg_write;

  rv_result u_result (
    .clk(clk), .rst_n(rst_n), .rs1(rf_rs1), .rs2(rs2), .rd(rd), .we(rf_we),
    .sel_load(is_load), .sel_link(is_jal), .alu_y(alu_y), .load_data(rdata),
    .link(link), .a(a), .b(b)
  );

  // Bus outputs follow the state directly
  assign arvalid = state == st_fetch_addr || state == st_load_addr;
  assign araddr  = (state == st_load_addr) ? alu_y : pc;
  assign rready  = state == st_fetch_data || state == st_load_data;
  assign awvalid = state == st_store;
  assign wvalid  = state == st_store;
  assign awaddr  = alu_y;
  assign wdata   = b;
  assign wstrb   = 4'hf;
  assign bready  = state == st_store_resp;
  assign trap    = state == st_halted;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_fetch_addr;
      pc    <= rv_pkg::reset_pc;
      ir    <= '0;
    end else begin
      case (state)
        st_fetch_addr: if (arready) state <= st_fetch_data;
        st_fetch_data: begin
          if (rvalid) begin
            ir    <= rdata;
            state <= (rresp == 2'b00) ? st_execute : st_halted;
          end
        end
        st_execute: begin
          if (illegal) begin
            state <= st_halted;
          end else if (is_load) begin
            state <= st_load_addr;
          end else if (is_store) begin
            state <= st_store;
          end else begin
            pc    <= next_pc;
            state <= st_fetch_addr;
          end
        end
        st_load_addr: if (arready) state <= st_load_data;
        st_load_data: begin
          if (load_done) begin
            pc    <= next_pc;
            state <= st_fetch_addr;
          end else if (rvalid) begin
            state <= st_halted;
          end
        end
        // Slave takes address and data together
        st_store: if (awready && wready) state <= st_store_resp;
        st_store_resp: begin
          if (bvalid) begin
            pc    <= next_pc;
            state <= (bresp == 2'b00) ? st_fetch_addr : st_halted;
          end
        end
        default: state <= st_halted;
      endcase
    end
  end

  a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("core: araddr or arvalid changed before arready");

endmodule

/* rtl/axi_mem_gpio.sv */
/*
 * Single-beat AXI slave with a word RAM preloaded from prog.hex
 * and a GPIO output register mapped at the GPIO address.
 */
`timescale 1ns/1ps

module axi_mem_gpio #(
  parameter int mem_words  = 256,
  parameter int gpio_width = 18
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [31:0]           awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [31:0]           wdata,
  input  logic [3:0]            wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [31:0]           araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [31:0]           rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [gpio_width-1:0] gpio
);

  localparam int idx_bits = $clog2(mem_words);

  logic [31:0]         mem [mem_words];
  logic [idx_bits-1:0] rd_idx, wr_idx;
  logic [31:0]         gpio_word, gpio_merged;
  logic                rd_accept, wr_accept, wr_gpio;

  initial $readmemh("prog.hex", mem);

  assign rd_idx    = araddr[idx_bits+1:2];
  assign wr_idx    = awaddr[idx_bits+1:2];
  assign rd_accept = arvalid && arready;
  assign wr_accept = awvalid && awready && wvalid && wready;
  assign wr_gpio   = awaddr == rv_pkg::gpio_addr;
  assign gpio_word = 32'(gpio);
  assign wready    = awready;
  assign bresp     = 2'b00;
  assign rresp     = 2'b00;

  // Byte lanes merged into the current GPIO value
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      gpio_merged[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : gpio_word[8*i +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept && !wr_gpio) begin
      for (int i = 0; i < 4; i++) begin
        if (wstrb[i]) mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
    if (rd_accept) rdata <= (araddr == rv_pkg::gpio_addr) ? gpio_word : mem[rd_idx];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      awready <= 1'b0;
      bvalid  <= 1'b0;
      gpio    <= '0;
    end else begin
      // Ready pulses one cycle after the request shows up
      arready <= arvalid && !arready && !rvalid;
      awready <= awvalid && wvalid && !awready && !bvalid;
      if (rd_accept) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
      if (wr_accept) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (wr_accept && wr_gpio) gpio <= gpio_merged[gpio_width-1:0];
    end
  end

  a_resp_cause: assert property (@(posedge clk) disable iff (!rst_n)
    ($rose(rvalid) |-> $past(rd_accept)) and ($rose(bvalid) |-> $past(wr_accept)))
    else $error("slave: response raised without an accepted address");

endmodule

/* rtl/fpga_top.sv */
/*
 * Board top level. The core drives the memory and GPIO slave over AXI;
 * GPIO and the trap flag go to the pins.
 */
`timescale 1ns/1ps

module fpga_top #(
  parameter int mem_words  = 256,
  parameter int gpio_width = 18
) (
  input  logic                  clk_clk,
  input  logic                  rst_n,
  output logic [gpio_width-1:0] gpio,
  output logic                  trap
);

  logic [31:0] awaddr, wdata, araddr, rdata;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;

  riscv_core riscv_core_0 (
    .clk(clk_clk),
    .*
  );

  axi_mem_gpio #(
    .mem_words (mem_words),
    .gpio_width(gpio_width)
  ) axi_mem_gpio_0 (
    .clk(clk_clk),
    .*
  );

endmodule

/* tb/tb_clock.sv */
/*
 * Testbench clock and reset source. 100 ns clock period, with rst_n held
 * low for a fixed number of cycles and released just after a rising edge.
 */
`timescale 1ns/1ps

module tb_clock #(
  parameter int half_period  = 50,
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // Release a little after the edge, like all other stimulus
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

/* tb/tb_fpga_top.sv */
/*
 * Testbench for the FPGA top level. Runs the program in prog.hex, checks
 * each GPIO value it emits against a table, then checks the trap halt.
 */
`timescale 1ns/1ps

module tb_fpga_top;

  localparam int          gpio_width  = 18;
  localparam int          wait_cycles = 2000;
  localparam int          hold_cycles = 200;
  localparam logic [31:0] poison      = 32'h0000_07ad;

  logic                  clk;
  logic                  rst_n;
  logic [gpio_width-1:0] gpio;
  logic                  trap;
  logic [31:0]           expected [$];
  logic [gpio_width-1:0] last_gpio;

  tb_clock u_clock (
    .clk  (clk),
    .rst_n(rst_n)
  );

  fpga_top i_dut (
    .clk_clk(clk),
    .rst_n  (rst_n),
    .gpio   (gpio),
    .trap   (trap)
  );

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // GPIO values in program order, from RV32I semantics of prog.hex
  function automatic void build_table();
    logic [31:0] x1, x2, x3, x4, x5, x6, x7, x8, x9, sum;
    // lui x10, 0x1 puts the GPIO address 0x1000 in x10
    x1 = 32'd5;                                   // addi x1, x0, 5
    expected.push_back(x1);                       // sw x1, 0(x10)
    x2 = -32'sd3;                                 // addi x2, x0, -3
    expected.push_back(x2);
    x3 = 32'h12 << 12;                            // lui x3, 0x12
    expected.push_back(x3);
    x4 = x1 + x3;                                 // add x4, x1, x3
    expected.push_back(x4);
    x5 = x1 - x2;                                 // sub x5, x1, x2
    expected.push_back(x5);
    x6 = x1 | 32'h30;                             // ori x6, x1, 0x30
    expected.push_back(x6);
    x7 = x4 & x6;                                 // and x7, x4, x6
    expected.push_back(x7);
    x8 = x3 | x5;                                 // or x8, x3, x5
    expected.push_back(x8);
    x9 = x4 ^ x5;                                 // xor x9, x4, x5
    expected.push_back(x9);
    x9 = x9 ^ 32'hffff_ffff;                      // xori x9, x9, -1
    expected.push_back(x9);
    expected.push_back(($signed(x2) < $signed(x1)) ? 32'd1 : 32'd0);  // slt x11, x2, x1
    expected.push_back(($signed(x1) < $signed(x2)) ? 32'd1 : 32'd0);  // slt x12, x1, x2
    // sw of 100, -40 and 7 to 0x200..0x208, three lw back, two adds into x18
    sum = 32'd100 + (-32'sd40) + 32'd7;
    expected.push_back(sum);
    // Loop at 0xa0: sw x19; addi x19, x19, -1; bne x19, x0 back to 0xa0
    for (int n = 3; n > 0; n--) begin
      expected.push_back(n);
    end
    // beq at 0xac and jal x21 at 0xb4 both jump over a store of x20
    expected.push_back(32'h0000_00b4 + 32'd4);   // sw x21 gives the jal link
    expected.push_back(32'd0);                    // addi x0, x0, 123 then sw x0
  endfunction

  task automatic check_reset();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!rst_n && cycles < 100) begin
      assert (gpio == '0 && !trap)
        else stop_with_error($sformatf("Mismatch at %0t: gpio %h trap %b during reset",
                                       $time, gpio, trap));
      @(negedge clk);
      cycles++;
    end
    assert (rst_n) else stop_with_error("Reset was never released");
    // First cycles after release, before any store can land
    repeat (2) begin
      assert (gpio == '0 && !trap)
        else stop_with_error($sformatf("Mismatch at %0t: gpio %h trap %b after reset",
                                       $time, gpio, trap));
      @(negedge clk);
    end
  endtask

  task automatic wait_gpio_change(input logic [gpio_width-1:0] old_value);
    int cycles;
    cycles = 0;
    while (gpio === old_value && cycles < wait_cycles) begin
      @(negedge clk);
      cycles++;
    end
    assert (gpio !== old_value)
      else stop_with_error($sformatf("Timed out waiting for gpio to leave %h", old_value));
  endtask

  task automatic wait_trap();
    int cycles;
    cycles = 0;
    while (!trap && cycles < wait_cycles) begin
      @(negedge clk);
      cycles++;
    end
    assert (trap) else stop_with_error("Timed out waiting for trap after the illegal word");
  endtask

  task automatic check_hold(input logic [gpio_width-1:0] final_value);
    repeat (hold_cycles) begin
      @(negedge clk);
      assert (gpio == final_value && trap)
        else stop_with_error($sformatf("Mismatch at %0t: gpio %h trap %b after halt, want %h",
                                       $time, gpio, trap, final_value));
    end
  endtask

  initial begin
    logic [gpio_width-1:0] want;
    build_table();
    check_reset();
    last_gpio = '0;
    foreach (expected[i]) begin
      want = expected[i][gpio_width-1:0];
      wait_gpio_change(last_gpio);
      assert (gpio != poison[gpio_width-1:0])
        else stop_with_error($sformatf("Mismatch at %0t: skipped store reached gpio (%h)",
                                       $time, gpio));
      assert (gpio == want && !trap)
        else stop_with_error($sformatf("Mismatch at %0t: entry %0d gpio %h trap %b, want %h",
                                       $time, i, gpio, trap, want));
      last_gpio = gpio;
    end
    wait_trap();
    check_hold(last_gpio);
    $display("All checks passed");
    $finish;
  end

endmodule

/* prog.hex */
// Test program, one 32-bit instruction word per column, four words per row
// The comment after each row is the byte address of its first word
00001537 00500093 00152023 FFD00113 // 0x00
00252023 000121B7 00352023 00308233 // 0x10
00452023 402082B3 00552023 0300E313 // 0x20
00652023 006273B3 00752023 0051E433 // 0x30
00852023 005244B3 00952023 FFF4C493 // 0x40
00952023 001125B3 00B52023 0020A633 // 0x50
00C52023 20000693 06400713 00E6A023 // 0x60
FD800713 00E6A223 00700713 00E6A423 // 0x70
0006A783 0046A803 0086A883 01078933 // 0x80
01190933 01252023 00300993 7AD00A13 // 0x90
01352023 FFF98993 FE099CE3 00098463 // 0xa0
01452023 00800AEF 01452023 01552023 // 0xb0
07B00013 00052023 FFFFFFFF          // 0xc0

/* vlog.f */
rtl/rv_pkg.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/riscv_core.sv
rtl/axi_mem_gpio.sv
rtl/fpga_top.sv
tb/tb_clock.sv
tb/tb_fpga_top.sv

/* run.sh */
#!/bin/sh
# Build and run from the project root so prog.hex is found
cd "$(dirname "$0")" &&
  verilator --binary --assert --top-module tb_fpga_top -f vlog.f -o sim_tb &&
  ./obj_dir/sim_tb | tee /dev/stderr | grep -q "All checks passed" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
